// File: common/sysbus_pkg.sv
package sysbus_pkg;

// ---------------------------------------------------------------------
// sizing
// ---------------------------------------------------------------------

	// bus field widths
	localparam int DATA_W = 16;
	localparam int ADDR_W = 16;
	localparam int NB_W = 4;

	// memory: present blocks and words per block
	localparam int MEM_SEGMENTS = 4;
	localparam int MEM_SEG_WORDS = 256;

	// i/o channel registers
	localparam int IO_CHANNELS = 4;

	// no-answer watchdog limit, in cycles from the command edge
	localparam int BUS_TIMEOUT = 16;

	// requester ports on the switch
	localparam int NUM_REQ = 2;

	// derived index widths
	localparam int SEG_W = $clog2(MEM_SEGMENTS);
	localparam int WORD_W = $clog2(MEM_SEG_WORDS);
	localparam int CHAN_W = $clog2(IO_CHANNELS);
	localparam int WD_W = $clog2(BUS_TIMEOUT);
	localparam int REQ_W = $clog2(NUM_REQ);

// ---------------------------------------------------------------------
// bus lines
// ---------------------------------------------------------------------

	// command lines, driven by the requester holding the bus
	typedef struct packed {
		logic w;
		logic r;
		logic in;
		// upper/lower address space, travels with the address
		logic pn;
		logic [NB_W-1:0] nb;
		logic [ADDR_W-1:0] ad;
		logic [DATA_W-1:0] dt;
	} bus_cmd_t;

	// answer lines, exactly one of ok/en/pe per transfer
	typedef struct packed {
		logic ok;
		logic en;
		logic pe;
		logic [DATA_W-1:0] dt;
	} bus_rsp_t;

	// all command and answer lines low
	localparam bus_cmd_t CMD_IDLE = '0;
	localparam bus_rsp_t RSP_NONE = '0;

	// a command is up when any of w, r, in is set
	function automatic logic cmd_active(input bus_cmd_t c);
		return c.w | c.r | c.in;
	endfunction

	// some answer is on the lines
	function automatic logic rsp_any(input bus_rsp_t a);
		return a.ok | a.en | a.pe;
	endfunction

endpackage

// File: verilog/bus_switch.sv
`timescale 1ns/1ps

module bus_switch (
	input logic clk_sys,
	input logic rst_n,
	input logic [sysbus_pkg::NUM_REQ-1:0] zw,
	output logic [sysbus_pkg::NUM_REQ-1:0] zg,
	input sysbus_pkg::bus_cmd_t cmd_0,
	input sysbus_pkg::bus_cmd_t cmd_1,
	output sysbus_pkg::bus_rsp_t rsp_0,
	output sysbus_pkg::bus_rsp_t rsp_1,
	output sysbus_pkg::bus_cmd_t mem_cmd,
	output sysbus_pkg::bus_cmd_t io_cmd,
	input sysbus_pkg::bus_rsp_t mem_rsp,
	input sysbus_pkg::bus_rsp_t io_rsp
);

	import sysbus_pkg::*;

// ---------------------------------------------------------------------
// arbiter
// ---------------------------------------------------------------------

	typedef enum logic {ARB_IDLE, ARB_BUSY} arb_state_t;

	arb_state_t state;
	logic [REQ_W-1:0] gnt_idx;
	logic [REQ_W-1:0] win_idx;

	// fixed priority, lowest index wins
	always_comb begin
		win_idx = '0;
		for (int i = NUM_REQ - 1; i >= 0; i--) begin
			if (zw[i])
				win_idx = REQ_W'(i);
		end
	end

	// grant held until the owner drops zw
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			state <= ARB_IDLE;
			gnt_idx <= '0;
		end else begin
			case (state)
				ARB_IDLE:
					if (|zw) begin
						state <= ARB_BUSY;
						gnt_idx <= win_idx;
					end
				default:
					// zg falls one cycle after zw
					if (!zw[gnt_idx])
						state <= ARB_IDLE;
			endcase
		end
	end

	always_comb begin
		for (int i = 0; i < NUM_REQ; i++)
			zg[i] = (state == ARB_BUSY) && (gnt_idx == REQ_W'(i));
	end

// ---------------------------------------------------------------------
// command routing
// ---------------------------------------------------------------------

	bus_cmd_t cmd_g;
	logic cmd_up;

	assign cmd_g = (gnt_idx == REQ_W'(1)) ? cmd_1 : cmd_0;
	assign cmd_up = (state == ARB_BUSY) && cmd_active(cmd_g);

	// in selects the i/o port, the other responder sees idle
	assign mem_cmd = (cmd_up && !cmd_g.in) ? cmd_g : CMD_IDLE;
	assign io_cmd = (cmd_up && cmd_g.in) ? cmd_g : CMD_IDLE;

// ---------------------------------------------------------------------
// watchdog
// ---------------------------------------------------------------------

	logic [WD_W-1:0] wd_cnt;
	logic wd_pe;
	logic answered;

	assign answered = rsp_any(mem_rsp) | rsp_any(io_rsp);

	// counts from the command edge while nobody answers
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			wd_cnt <= '0;
			wd_pe <= 1'b0;
		end else if (!cmd_up) begin
			wd_cnt <= '0;
			wd_pe <= 1'b0;
		end else if (!wd_pe && !answered) begin
			if (wd_cnt == WD_W'(BUS_TIMEOUT - 1))
				wd_pe <= 1'b1;
			else
				wd_cnt <= wd_cnt + 1'b1;
		end
	end

// ---------------------------------------------------------------------
// answer merge
// ---------------------------------------------------------------------

	bus_rsp_t rsp_mrg;

	always_comb begin
		rsp_mrg = mem_rsp | io_rsp;
		// watchdog pe held until the command goes idle
		rsp_mrg.pe = rsp_mrg.pe | wd_pe;
	end

	// only the granted requester sees the answer
	assign rsp_0 = zg[0] ? rsp_mrg : RSP_NONE;
	assign rsp_1 = zg[1] ? rsp_mrg : RSP_NONE;

endmodule

// File: mem/mem_block.sv
`timescale 1ns/1ps

module mem_block (
	input logic clk_sys,
	input logic rst_n,
	input sysbus_pkg::bus_cmd_t cmd,
	output sysbus_pkg::bus_rsp_t rsp
);

	import sysbus_pkg::*;

// ---------------------------------------------------------------------
// storage
// ---------------------------------------------------------------------

	// one row per present block
	logic [DATA_W-1:0] mem [MEM_SEGMENTS][MEM_SEG_WORDS];

	logic [SEG_W-1:0] seg;
	logic [WORD_W-1:0] word;
	logic seg_ok;

	// low address bits only, upper bits ignored
	assign seg = cmd.nb[SEG_W-1:0];
	assign word = cmd.ad[WORD_W-1:0];

	// missing block, stay silent and let the watchdog end it
	assign seg_ok = int'(cmd.nb) < MEM_SEGMENTS;

// ---------------------------------------------------------------------
// command decode
// ---------------------------------------------------------------------

	logic act;
	logic act_q;
	logic first;
	logic mem_we;

	// memory commands only, i/o goes elsewhere
	assign act = (cmd.w | cmd.r) && !cmd.in;

	// first cycle of a held command
	assign first = act && !act_q;

	// one store per command
	assign mem_we = first && seg_ok && cmd.w;

	always_ff @(posedge clk_sys) begin
		if (mem_we)
			mem[seg][word] <= cmd.dt;
	end

// ---------------------------------------------------------------------
// answer
// ---------------------------------------------------------------------

	// answer registered on the first cycle, held while the command holds
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			act_q <= 1'b0;
			rsp <= RSP_NONE;
		end else begin
			act_q <= act;
			if (!act) begin
				// cleared one cycle after the command drops
				rsp <= RSP_NONE;
			end else if (first && seg_ok) begin
				rsp.ok <= 1'b1;
				rsp.en <= 1'b0;
				rsp.pe <= 1'b0;
				// read data, writes return zero
				if (cmd.r)
					rsp.dt <= mem[seg][word];
				else
					rsp.dt <= '0;
			end
		end
	end

endmodule

// File: verilog/io_port.sv
`timescale 1ns/1ps

module io_port (
	input logic clk_sys,
	input logic rst_n,
	input sysbus_pkg::bus_cmd_t cmd,
	output sysbus_pkg::bus_rsp_t rsp
);

	import sysbus_pkg::*;

// ---------------------------------------------------------------------
// channel registers
// ---------------------------------------------------------------------

	logic [DATA_W-1:0] chan [IO_CHANNELS];

	logic [CHAN_W-1:0] sel;
	logic chan_ok;
	logic act;
	logic act_q;
	logic first;

	// channel number from the low ad bits
	assign sel = cmd.ad[CHAN_W-1:0];
	assign chan_ok = int'(cmd.ad) < IO_CHANNELS;

	// i/o read or write
	assign act = cmd.in && (cmd.w | cmd.r);
	assign first = act && !act_q;

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			for (int i = 0; i < IO_CHANNELS; i++)
				chan[i] <= '0;
		end else if (first && chan_ok && cmd.w) begin
			chan[sel] <= cmd.dt;
		end
	end

// ---------------------------------------------------------------------
// answer
// ---------------------------------------------------------------------

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			act_q <= 1'b0;
			rsp <= RSP_NONE;
		end else begin
			act_q <= act;
			if (!act) begin
				rsp <= RSP_NONE;
			end else if (first) begin
				// unknown channel is refused with en
				rsp.ok <= chan_ok;
				rsp.en <= !chan_ok;
				rsp.pe <= 1'b0;
				if (chan_ok && cmd.r)
					rsp.dt <= chan[sel];
				else
					rsp.dt <= '0;
			end
		end
	end

endmodule

// File: verilog/sysbus_top.sv
`timescale 1ns/1ps

module sysbus_top (
	input logic clk_sys,
	input logic rst_n,
	// requester reservation lines
	input logic [sysbus_pkg::NUM_REQ-1:0] zw,
	output logic [sysbus_pkg::NUM_REQ-1:0] zg,
	// processor port
	input sysbus_pkg::bus_cmd_t cmd_0,
	output sysbus_pkg::bus_rsp_t rsp_0,
	// i/o bridge port
	input sysbus_pkg::bus_cmd_t cmd_1,
	output sysbus_pkg::bus_rsp_t rsp_1
);

	import sysbus_pkg::*;

// ---------------------------------------------------------------------
// switch
// ---------------------------------------------------------------------

	// switch to responders
	bus_cmd_t mem_cmd;
	bus_cmd_t io_cmd;

	// responders back to the switch
	bus_rsp_t mem_rsp;
	bus_rsp_t io_rsp;

	bus_switch u_bus_switch (
		.clk_sys(clk_sys),
		.rst_n(rst_n),
		.zw(zw),
		.zg(zg),
		.cmd_0(cmd_0),
		.cmd_1(cmd_1),
		.rsp_0(rsp_0),
		.rsp_1(rsp_1),
		.mem_cmd(mem_cmd),
		.io_cmd(io_cmd),
		.mem_rsp(mem_rsp),
		.io_rsp(io_rsp)
	);

// ---------------------------------------------------------------------
// responders
// ---------------------------------------------------------------------

	// segmented word store
	mem_block u_mem_block (
		.clk_sys(clk_sys),
		.rst_n(rst_n),
		.cmd(mem_cmd),
		.rsp(mem_rsp)
	);

	// channel registers
	io_port u_io_port (
		.clk_sys(clk_sys),
		.rst_n(rst_n),
		.cmd(io_cmd),
		.rsp(io_rsp)
	);

endmodule

// File: verif/sysbus_assertions.sv
`timescale 1ns/1ps

module sysbus_assertions (
	input logic clk_sys,
	input logic rst_n,
	input logic [sysbus_pkg::NUM_REQ-1:0] zw,
	input logic [sysbus_pkg::NUM_REQ-1:0] zg,
	input sysbus_pkg::bus_cmd_t cmd_0,
	input sysbus_pkg::bus_cmd_t cmd_1,
	input sysbus_pkg::bus_rsp_t rsp_0,
	input sysbus_pkg::bus_rsp_t rsp_1
);

	// bus owned by one requester at most, and only by one that asks or just let go
	zg_onehot: assert property (@(posedge clk_sys) disable iff (!rst_n)
		$onehot0(zg) && ((zg & ~(zw | $past(zw))) == '0))
		else $error("zg not one-hot or held by an idle requester");

	// synchronous reset clears the arbiter
	zg_reset: assert property (@(posedge clk_sys) !rst_n |=> zg == '0)
		else $error("zg up during reset");

	// ok, en and pe exclude each other
	rsp_0_kind: assert property (@(posedge clk_sys) disable iff (!rst_n)
		$onehot0({rsp_0.ok, rsp_0.en, rsp_0.pe}))
		else $error("rsp_0 carries more than one answer");
	rsp_1_kind: assert property (@(posedge clk_sys) disable iff (!rst_n)
		$onehot0({rsp_1.ok, rsp_1.en, rsp_1.pe}))
		else $error("rsp_1 carries more than one answer");

	// answer frozen while the granted command holds
	rsp_0_hold: assert property (@(posedge clk_sys) disable iff (!rst_n)
		(zg[0] && (cmd_0.w | cmd_0.r | cmd_0.in) && (rsp_0.ok | rsp_0.en | rsp_0.pe))
		|=> $stable(rsp_0))
		else $error("rsp_0 changed while cmd_0 was held");
	rsp_1_hold: assert property (@(posedge clk_sys) disable iff (!rst_n)
		(zg[1] && (cmd_1.w | cmd_1.r | cmd_1.in) && (rsp_1.ok | rsp_1.en | rsp_1.pe))
		|=> $stable(rsp_1))
		else $error("rsp_1 changed while cmd_1 was held");

endmodule

bind bus_switch sysbus_assertions u_sysbus_assertions (
	.clk_sys(clk_sys),
	.rst_n(rst_n),
	.zw(zw),
	.zg(zg),
	.cmd_0(cmd_0),
	.cmd_1(cmd_1),
	.rsp_0(rsp_0),
	.rsp_1(rsp_1)
);

// File: verif/sysbus_tb.sv
`timescale 1ns/1ps

module sysbus_tb;

	import sysbus_pkg::*;

	// one finished transfer for the compare process
	typedef struct packed {
		logic port;
		bus_cmd_t c;
		bus_rsp_t a;
	} xfer_rec_t;

	logic clk_sys;
	logic rst_n;
	logic [NUM_REQ-1:0] zw;
	logic [NUM_REQ-1:0] zg;
	bus_cmd_t cmd_0;
	bus_cmd_t cmd_1;
	bus_rsp_t rsp_0;
	bus_rsp_t rsp_1;

	// shadow state behind the reference model
	logic [DATA_W-1:0] shadow_mem [MEM_SEGMENTS][MEM_SEG_WORDS];
	logic [DATA_W-1:0] shadow_chan [IO_CHANNELS];
	xfer_rec_t done_q[$];
	int cyc;
	int grant_cyc [NUM_REQ];
	int rel_cyc [NUM_REQ];
	int checks;
	int errors;
	int tests;
	int tests_failed;

	sysbus_top u_sysbus_top (.*);

	initial begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys;
	end

	always @(posedge clk_sys)
		cyc <= cyc + 1;

// ---------------------------------------------------------------------
// reference model
// ---------------------------------------------------------------------

	function automatic bus_cmd_t make_cmd(input logic w, input logic r, input logic in,
			input int nb, input int ad, input logic [DATA_W-1:0] dt);
		bus_cmd_t c;
		c = '0;
		c.w = w;
		c.r = r;
		c.in = in;
		c.nb = NB_W'(nb);
		c.ad = ADDR_W'(ad);
		c.dt = dt;
		return c;
	endfunction

	// answer expected from the bus rules and the shadow state
	function automatic bus_rsp_t expected_rsp(input bus_cmd_t c);
		bus_rsp_t e;
		e = '0;
		if (c.in) begin
			// unknown channel refused
			e.ok = int'(c.ad) < IO_CHANNELS;
			e.en = !e.ok;
			if (e.ok && c.r)
				e.dt = shadow_chan[int'(c.ad)];
		end else if (int'(c.nb) < MEM_SEGMENTS) begin
			e.ok = 1'b1;
			if (c.r)
				e.dt = shadow_mem[int'(c.nb)][int'(c.ad) % MEM_SEG_WORDS];
		end else begin
			// nobody answers so the watchdog ends it
			e.pe = 1'b1;
		end
		return e;
	endfunction

	function automatic void apply_shadow(input bus_cmd_t c, input bus_rsp_t e);
		if (e.ok && c.w && c.in)
			shadow_chan[int'(c.ad)] = c.dt;
		else if (e.ok && c.w)
			shadow_mem[int'(c.nb)][int'(c.ad) % MEM_SEG_WORDS] = c.dt;
	endfunction

	function automatic bus_rsp_t port_rsp(input int port);
		return (port == 0) ? rsp_0 : rsp_1;
	endfunction

// ---------------------------------------------------------------------
// checks
// ---------------------------------------------------------------------

	task automatic report_field(input string name, input logic [DATA_W-1:0] got,
			input logic [DATA_W-1:0] exp);
		errors++;
		$display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
	endtask

	task automatic check_rsp(input string name, input bus_rsp_t got, input bus_rsp_t exp,
			input logic cmp_dt);
		checks++;
		if (got.ok !== exp.ok)
			report_field({name, ".ok"}, DATA_W'(got.ok), DATA_W'(exp.ok));
		if (got.en !== exp.en)
			report_field({name, ".en"}, DATA_W'(got.en), DATA_W'(exp.en));
		if (got.pe !== exp.pe)
			report_field({name, ".pe"}, DATA_W'(got.pe), DATA_W'(exp.pe));
		if (cmp_dt && got.dt !== exp.dt)
			report_field({name, ".dt"}, got.dt, exp.dt);
	endtask

	// winner -1 means nobody holds the bus
	task automatic check_grant(input logic [NUM_REQ-1:0] got, input int winner);
		logic [NUM_REQ-1:0] exp;
		exp = '0;
		if (winner >= 0)
			exp[winner] = 1'b1;
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Fail zg: got 0x%h, expected 0x%h", got, exp);
		end
	endtask

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("tests %0d, failed %0d, checks %0d, errors %0d", tests, tests_failed,
			checks, errors + 1);
		$display("Simulation failed");
		$finish;
	endtask

	// what is 0 for grant up, 1 for answer up, 2 for answer down, 3 for grant down
	task automatic wait_for(input int port, input int what, input int limit, input string why);
		bus_rsp_t a;
		logic hit;
		int n;
		n = 0;
		hit = 1'b0;
		while (!hit) begin
			@(negedge clk_sys);
			a = port_rsp(port);
			case (what)
				0: hit = zg[port];
				1: hit = a.ok | a.en | a.pe;
				2: hit = !(a.ok | a.en | a.pe);
				default: hit = !zg[port];
			endcase
			n++;
			if (!hit && n >= limit)
				abort_run($sformatf("port %0d: %s", port, why));
		end
	endtask

	task automatic drive_cmd(input int port, input bus_cmd_t c);
		if (port == 0)
			cmd_0 = c;
		else
			cmd_1 = c;
	endtask

// ---------------------------------------------------------------------
// requester driver
// ---------------------------------------------------------------------

	// full four-phase handshake with the command held for hold extra cycles
	task automatic bus_xfer(input int port, input bus_cmd_t c, input int hold);
		bus_rsp_t got;
		xfer_rec_t rec;
		@(posedge clk_sys);
		#1 zw[port] = 1'b1;
		wait_for(port, 0, 64, "the grant never came");
		grant_cyc[port] = cyc;
		check_grant(zg, port);
		@(posedge clk_sys);
		#1 drive_cmd(port, c);
		wait_for(port, 1, BUS_TIMEOUT + 8, "the answer never came");
		got = port_rsp(port);
		// answer frozen and bus kept while we hold
		for (int i = 0; i < hold; i++) begin
			@(negedge clk_sys);
			check_rsp($sformatf("rsp_%0d", port), port_rsp(port), got, 1'b1);
			check_grant(zg, port);
		end
		@(posedge clk_sys);
		#1 drive_cmd(port, CMD_IDLE);
		wait_for(port, 2, 8, "the answer never dropped");
		@(posedge clk_sys);
		#1 zw[port] = 1'b0;
		rel_cyc[port] = cyc;
		wait_for(port, 3, 8, "the grant never dropped");
		rec.port = 1'(port);
		rec.c = c;
		rec.a = got;
		done_q.push_back(rec);
	endtask

	// compare process in completion order
	initial begin
		xfer_rec_t rec;
		bus_rsp_t exp;
		forever begin
			@(negedge clk_sys);
			while (done_q.size() > 0) begin
				rec = done_q.pop_front();
				exp = expected_rsp(rec.c);
				check_rsp($sformatf("rsp_%0d", rec.port), rec.a, exp, rec.c.r & exp.ok);
				apply_shadow(rec.c, exp);
			end
		end
	end

	task automatic end_test(input string name, input int err0);
		int n;
		n = 0;
		while (done_q.size() > 0) begin
			@(negedge clk_sys);
			n++;
			if (n > 16)
				abort_run("compare queue never drained");
		end
		tests++;
		if (errors != err0) begin
			tests_failed++;
			$display("test %0d %s: failed", tests, name);
		end else begin
			$display("test %0d %s: ok", tests, name);
		end
	endtask

// ---------------------------------------------------------------------
// test sequence
// ---------------------------------------------------------------------

	initial begin
		int e0;
		int a;
		int hold;
		int addr [MEM_SEGMENTS];
		void'($urandom(49183));
		rst_n = 1'b0;
		zw = '0;
		cmd_0 = CMD_IDLE;
		cmd_1 = CMD_IDLE;
		repeat (8) @(posedge clk_sys);
		#1 rst_n = 1'b1;

		// writes carry random upper address bits that the read drops
		e0 = errors;
		for (int s = 0; s < MEM_SEGMENTS; s++) begin
			for (int k = 0; k < 3; k++) begin
				a = int'($urandom % MEM_SEG_WORDS);
				if (k == 0)
					addr[s] = a;
				bus_xfer(0, make_cmd(1'b1, 1'b0, 1'b0, s,
					a + MEM_SEG_WORDS * int'($urandom % 256), 16'($urandom)), 0);
				bus_xfer(0, make_cmd(1'b0, 1'b1, 1'b0, s, a, 16'h0), 0);
			end
		end
		end_test("memory write/read", e0);

		// missing blocks leave the word in the present block unchanged
		e0 = errors;
		for (int s = 0; s < MEM_SEGMENTS; s++) begin
			bus_xfer(0, make_cmd(1'b1, 1'b0, 1'b0, MEM_SEGMENTS + s, addr[s], 16'($urandom)), 0);
			bus_xfer(0, make_cmd(1'b0, 1'b1, 1'b0, MEM_SEGMENTS + s, addr[s], 16'h0), 0);
			bus_xfer(0, make_cmd(1'b0, 1'b1, 1'b0, s, addr[s], 16'h0), 0);
		end
		end_test("block out of range", e0);

		// channels 4 and 5 are refused
		e0 = errors;
		for (int ch = 0; ch < IO_CHANNELS + 2; ch++)
			bus_xfer(1, make_cmd(1'b1, 1'b0, 1'b1, 0, ch, 16'($urandom)), 0);
		for (int ch = 0; ch < IO_CHANNELS + 2; ch++)
			bus_xfer(1, make_cmd(1'b0, 1'b1, 1'b1, 0, ch, 16'h0), 0);
		end_test("io channels", e0);

		// same-cycle requests where port 1 reads what port 0 wrote
		e0 = errors;
		fork
			bus_xfer(0, make_cmd(1'b1, 1'b0, 1'b0, 2, addr[2], 16'($urandom)), 0);
			bus_xfer(1, make_cmd(1'b0, 1'b1, 1'b0, 2, addr[2], 16'h0), 0);
		join
		checks++;
		if (!(grant_cyc[0] < grant_cyc[1] && grant_cyc[1] > rel_cyc[0])) begin
			errors++;
			$display("port 1 was granted before port 0 released the bus");
		end
		end_test("arbitration", e0);

		// port 1 asks while port 0 sits on the bus
		e0 = errors;
		hold = 3 + int'($urandom % 8);
		fork
			bus_xfer(0, make_cmd(1'b0, 1'b1, 1'b0, 1, addr[1], 16'h0), hold);
			begin
				@(posedge clk_sys);
				bus_xfer(1, make_cmd(1'b0, 1'b1, 1'b1, 0, 2, 16'h0), 0);
			end
		join
		end_test("back-pressure", e0);

		// reset while an i/o write is answered
		e0 = errors;
		@(posedge clk_sys);
		#1 zw[1] = 1'b1;
		wait_for(1, 0, 8, "the grant never came");
		@(posedge clk_sys);
		#1 cmd_1 = make_cmd(1'b1, 1'b0, 1'b1, 0, 1, 16'($urandom));
		wait_for(1, 1, 8, "the answer never came");
		@(posedge clk_sys);
		#1 rst_n = 1'b0;
		// synchronous reset takes effect on the next edge
		@(posedge clk_sys);
		@(negedge clk_sys);
		check_grant(zg, -1);
		check_rsp("rsp_1", rsp_1, RSP_NONE, 1'b1);
		repeat (7) @(posedge clk_sys);
		#1 zw = '0;
		cmd_1 = CMD_IDLE;
		rst_n = 1'b1;
		for (int ch = 0; ch < IO_CHANNELS; ch++)
			shadow_chan[ch] = '0;
		for (int ch = 0; ch < IO_CHANNELS; ch++)
			bus_xfer(1, make_cmd(1'b0, 1'b1, 1'b1, 0, ch, 16'h0), 0);
		end_test("reset mid-transfer", e0);

		$display("tests %0d, failed %0d, checks %0d, errors %0d", tests, tests_failed,
			checks, errors);
		if (errors == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

// File: build.f
common/sysbus_pkg.sv
verilog/bus_switch.sv
mem/mem_block.sv
verilog/io_port.sv
verilog/sysbus_top.sv
verif/sysbus_assertions.sv
verif/sysbus_tb.sv

// File: Makefile
SRCS := $(shell cat build.f)

.PHONY: all run clean

all: obj_dir/Vsysbus_tb

obj_dir/Vsysbus_tb: build.f $(SRCS)
	verilator --binary --timing --assert -j 0 --top-module sysbus_tb -f build.f

run: obj_dir/Vsysbus_tb
	./obj_dir/Vsysbus_tb > sim.log 2>&1 || true
	cat sim.log
	grep -q "Simulation completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log
